//--- hdl/noise_params.svh
`ifndef NOISE_PARAMS_SVH
`define NOISE_PARAMS_SVH

// host register map
// bit 7 noise enable, bits 4..0 frequency code
`define NOISE_REG_NE_NFRQ   8'h0F
// coarse level, level[9:2]
`define NOISE_REG_LEVEL_HI  8'h10
// fine level, data[1:0] -> level[1:0]
`define NOISE_REG_LEVEL_LO  8'h11

// lfsr seed after reset, all ones
`define NOISE_LFSR_INIT     16'hffff

// output sample width, mix gets sign-extended to this
`define NOISE_SAMPLE_W      16

`endif // NOISE_PARAMS_SVH

//--- hdl/noise_pkg.sv
`default_nettype none

`include "noise_params.svh"

package noise_pkg;

    typedef logic [4:0]  slot_t;     // operator slot, 0..31
    typedef logic [4:0]  nfrq_t;     // noise frequency code
    typedef logic [9:0]  level_t;    // stands in for the envelope attenuation
    typedef logic [11:0] mix_t;      // noise mix word, msb is the sign
    typedef logic signed [`NOISE_SAMPLE_W-1:0] sample_t;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;

    // one host write
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

    // programmed noise setup, 16 bits
    typedef struct packed {
        logic   ne;      // noise enable
        nfrq_t  nfrq;
        level_t level;
    } noise_cfg_t;

    // write handshake fsm
    typedef enum logic {
        DEC_IDLE,
        DEC_ACK
    } dec_state_t;

endpackage

`default_nettype wire

//--- hdl/noise_reg_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "noise_params.svh"

// four-phase write port into the noise config register
module noise_reg_decode (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  wr_req,
    input  noise_pkg::reg_wr_t   wr,
    output logic                 wr_ack,
    output noise_pkg::noise_cfg_t cfg
);

    noise_pkg::dec_state_t state;

    // ack is the fsm state itself, no extra flop
    assign wr_ack = (state == noise_pkg::DEC_ACK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= noise_pkg::DEC_IDLE;
        end else begin
            case (state)
                noise_pkg::DEC_IDLE: begin
                    if (wr_req) begin
                        state <= noise_pkg::DEC_ACK;   // accepting edge
                    end
                end
                noise_pkg::DEC_ACK: begin
                    // hold ack until the host lets go of req
                    if (!wr_req) begin
                        state <= noise_pkg::DEC_IDLE;
                    end
                end
                default: state <= noise_pkg::DEC_IDLE;
            endcase
        end
    end

    // register update, only on the accepting edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (state == noise_pkg::DEC_IDLE && wr_req) begin
            case (wr.addr)
                `NOISE_REG_NE_NFRQ: begin
                    cfg.ne   <= wr.data[7];
                    cfg.nfrq <= wr.data[4:0];   // bits 6..5 ignored
                end
                `NOISE_REG_LEVEL_HI: begin
                    cfg.level[9:2] <= wr.data;    // coarse half alone
                end
                `NOISE_REG_LEVEL_LO: begin
                    cfg.level[1:0] <= wr.data[1:0];
                end
                default: begin
                    // unknown address, handshake still completes
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/noise_slot_counter.sv
`timescale 1ns/1ns
`default_nettype none

// operator slot position within the 32-slot frame
module noise_slot_counter (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,    // phase 1 enable
    output noise_pkg::slot_t    slot,
    output logic                op31
);

    // advance once per cen, 31 rolls over to 0 by width
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot <= '0;
        end else if (cen) begin
            slot <= slot + 5'd1;
        end
    end

    // last slot of the frame
    // decoded here once so downstream logic never compares slot numbers
    assign op31 = &slot;

endmodule

`default_nettype wire

//--- hdl/noise_lfsr_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "noise_params.svh"

// noise source: rate counter, 16-bit lfsr and slot 31 mix
module noise_lfsr_gen (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   cen,
    input  noise_pkg::slot_t      slot,
    input  wire                   op31,
    input  noise_pkg::noise_cfg_t cfg,
    output logic                  noise_bit,
    output noise_pkg::mix_t       mix,
    output logic                  mix_upd
);

    logic            update;       // lfsr takes the special feedback
    noise_pkg::nfrq_t cnt;         // period counter
    logic [15:0]     lfsr;
    logic            last;         // inverted bit 0 from the last update
    logic            fb;
    logic            all1;
    logic            sgn;

    assign noise_bit = lfsr[0];

    // period counter, ticks twice per frame (slot 15 and 31)
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            update <= 1'b0;
        end else if (cen) begin
            if (&slot[3:0]) begin
                cnt <= update ? 5'd0 : cnt + 5'd1;
            end
            update <= (~cfg.nfrq == cnt);  // sampled every cen
        end
    end

    // feedback into bit 15
    assign all1 = &lfsr;
    assign fb   = update ? ((all1 & ~last) | (lfsr[2] ^ last)) : ~lfsr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `NOISE_LFSR_INIT;
            last <= 1'b0;
        end else if (cen) begin
            lfsr <= {fb, lfsr[15:1]};       // shift right
            if (update) begin
                last <= ~lfsr[0];
            end
        end
    end

    // mix: sign is the inverted noise bit, level flipped with it
    assign sgn = ~lfsr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix     <= '0;
            mix_upd <= 1'b0;
        end else begin
            mix_upd <= cen & op31;          // strobes even while ne is clear
            if (cen && op31 && cfg.ne) begin
                mix <= {sgn, cfg.level[9:2] ^ {8{lfsr[0]}}, {3{sgn}}};
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/noise_sample_out.sv
`timescale 1ns/1ns
`default_nettype none

`include "noise_params.svh"

// sample register and valid strobe for downstream audio
module noise_sample_out (
    input  wire                 clk,
    input  wire                 rst,
    input  noise_pkg::mix_t     mix,
    input  wire                 mix_upd,
    output noise_pkg::sample_t  sample,
    output logic                sample_valid
);

    localparam int MIX_W = $bits(noise_pkg::mix_t);

    noise_pkg::sample_t sext;   // mix widened by sign

    assign sext = {{(`NOISE_SAMPLE_W - MIX_W){mix[MIX_W-1]}}, mix};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= mix_upd;     // single clock, mix_upd is a pulse
            if (mix_upd) begin
                sample <= sext;
            end
            // otherwise hold until the next frame
        end
    end

endmodule

`default_nettype wire

//--- hdl/noise_top.sv
`timescale 1ns/1ns
`default_nettype none

// noise channel top: host port, slot timing, generator, output stage
module noise_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    input  wire                 wr_req,
    input  noise_pkg::reg_wr_t  wr,
    output logic                wr_ack,
    output logic                noise_bit,
    output noise_pkg::sample_t  sample,
    output logic                sample_valid
);

    noise_pkg::noise_cfg_t cfg;
    noise_pkg::slot_t      slot;
    logic                  op31;
    noise_pkg::mix_t       mix;
    logic                  mix_upd;

    noise_reg_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .wr_req (wr_req),
        .wr     (wr),
        .wr_ack (wr_ack),
        .cfg    (cfg)
    );

    noise_slot_counter u_slot (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .slot (slot),
        .op31 (op31)
    );

    noise_lfsr_gen u_gen (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .slot      (slot),
        .op31      (op31),
        .cfg       (cfg),
        .noise_bit (noise_bit),
        .mix       (mix),
        .mix_upd   (mix_upd)
    );

    noise_sample_out u_out (
        .clk          (clk),
        .rst          (rst),
        .mix          (mix),
        .mix_upd      (mix_upd),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

//--- sim/noise_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "noise_params.svh"

module noise_tb;

    localparam int FRAME_CLKS  = 64;     // 32 slots with cen on every other clock
    localparam int MARGIN_CLKS = 1000;   // reset and register writes

    logic                  clk;
    logic                  rst;
    logic                  cen;
    logic                  wr_req;
    noise_pkg::reg_wr_t    wr;
    logic                  wr_ack;
    logic                  noise_bit;
    noise_pkg::sample_t    sample;
    logic                  sample_valid;

    // reference model state as it should be after each rising edge
    noise_pkg::slot_t      m_slot;
    noise_pkg::nfrq_t      m_cnt;
    logic                  m_update;
    logic [15:0]           m_lfsr;
    logic                  m_last;
    noise_pkg::mix_t       m_mix;
    logic                  m_mix_upd;
    noise_pkg::sample_t    m_sample;
    logic                  m_valid;
    logic                  m_ack;
    noise_pkg::noise_cfg_t m_cfg;

    // one entry per record of the input file
    int q_ne[$];
    int q_nfrq[$];
    int q_level[$];
    int q_jaddr[$];
    int q_jdata[$];
    int q_nsamp[$];
    int q_mode[$];
    int q_exp[$];
    int wd_clocks;

    noise_top dut (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .wr_req       (wr_req),
        .wr           (wr),
        .wr_ack       (wr_ack),
        .noise_bit    (noise_bit),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic reset_model();
        m_slot    = '0;
        m_cnt     = '0;
        m_update  = 1'b0;
        m_lfsr    = 16'hffff;   // seed
        m_last    = 1'b0;
        m_mix     = '0;
        m_mix_upd = 1'b0;
        m_sample  = '0;
        m_valid   = 1'b0;
        m_ack     = 1'b0;
        m_cfg     = '0;
    endtask

    // one rising edge with the inputs that were held across it
    task automatic advance_model();
        logic                  op_edge;
        logic                  out;
        logic                  fb;
        logic                  new_update;
        noise_pkg::noise_cfg_t cfg_next;
        op_edge  = cen && (m_slot == 5'd31);
        out      = m_lfsr[0];
        cfg_next = m_cfg;
        if (!m_ack && wr_req) begin   // accepting edge
            case (wr.addr)
                `NOISE_REG_NE_NFRQ: begin
                    cfg_next.ne   = wr.data[7];
                    cfg_next.nfrq = wr.data[4:0];
                end
                `NOISE_REG_LEVEL_HI: cfg_next.level[9:2] = wr.data;
                `NOISE_REG_LEVEL_LO: cfg_next.level[1:0] = wr.data[1:0];
                default: ;   // unknown address changes nothing
            endcase
        end
        m_ack = wr_req;   // ack trails req by one clock both ways
        m_valid = m_mix_upd;
        if (m_mix_upd)
            m_sample = 16'($signed(m_mix));
        m_mix_upd = op_edge;
        if (op_edge && m_cfg.ne)
            m_mix = {~out, m_cfg.level[9:2] ^ {8{out}}, {3{~out}}};
        if (cen) begin
            fb = m_update ? ((&m_lfsr && !m_last) || (m_lfsr[2] != m_last)) : ~out;
            if (m_update)
                m_last = ~out;
            new_update = (m_cnt == ~m_cfg.nfrq);
            if (m_slot[3:0] == 4'hf)
                m_cnt = m_update ? 5'd0 : m_cnt + 5'd1;
            m_update = new_update;
            m_lfsr   = {fb, m_lfsr[15:1]};
            m_slot   = m_slot + 5'd1;   // wraps 31 -> 0
        end
        m_cfg = cfg_next;
    endtask

    // wait out one clock then compare everything and drive the next cen
    task automatic step();
        @(negedge clk);
        advance_model();
        check_value("wr_ack", 32'(wr_ack), 32'(m_ack));
        check_value("noise_bit", 32'(noise_bit), 32'(m_lfsr[0]));
        check_value("sample_valid", 32'(sample_valid), 32'(m_valid));
        check_value("sample", 32'(sample), 32'(m_sample));
        cen = ~cen;
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
        int waited;
        wr.addr = addr;
        wr.data = data;
        wr_req  = 1'b1;
        waited  = 0;
        while (!wr_ack) begin
            if (waited == 8) abort_run("wr_ack never rose while wr_req was held");
            else begin
                step();
                waited++;
            end
        end
        wr_req = 1'b0;   // phase 3 where the host lets go
        waited = 0;
        while (wr_ack) begin
            if (waited == 8) abort_run("wr_ack stayed high after wr_req was dropped");
            else begin
                step();
                waited++;
            end
        end
    endtask

    task automatic next_strobe();
        step();
        while (!sample_valid) step();   // wait for the strobe
    endtask

    task automatic load_records();
        int    fd;
        int    n;
        int    f[8];
        string line;
        fd = $fopen("sim/noise_input.txt", "r");
        if (fd == 0) abort_run("could not open the stimulus file sim/noise_input.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments and blank lines
                n = $sscanf(line, "%d %h %h %h %h %d %d %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n == 8) begin
                    q_ne.push_back(f[0]);
                    q_nfrq.push_back(f[1]);
                    q_level.push_back(f[2]);
                    q_jaddr.push_back(f[3]);
                    q_jdata.push_back(f[4]);
                    q_nsamp.push_back(f[5]);
                    q_mode.push_back(f[6]);
                    q_exp.push_back(f[7]);
                end
            end
        end
        $fclose(fd);
        if (q_ne.size() == 0) abort_run("the stimulus file holds no test records");
    endtask

    task automatic run_record(input int r);
        logic [7:0] mag;
        int         k;
        host_write(`NOISE_REG_NE_NFRQ, {q_ne[r] != 0, 2'b00, 5'(q_nfrq[r])});
        host_write(`NOISE_REG_LEVEL_HI, 8'(q_level[r] >> 2));
        host_write(`NOISE_REG_LEVEL_LO, 8'(q_level[r] & 3));
        host_write(8'(q_jaddr[r]), 8'(q_jdata[r]));   // unknown address
        next_strobe();   // frame was under way while the registers changed
        for (k = 0; k < q_nsamp[r]; k++) begin
            next_strobe();
            mag = sample[10:3] ^ {8{~sample[15]}};   // undo the noise flip
            if (k == 0 && q_mode[r] == 1)
                check_value("sample magnitude", 32'(mag), 32'(q_exp[r]));
            if (k == 0 && q_mode[r] == 2)
                check_value("sample", 32'(sample), 32'(q_exp[r]));
        end
    endtask

    initial begin : watchdog
        wait (wd_clocks > 0);
        repeat (wd_clocks) @(posedge clk);
        abort_run("timeout, the tests did not finish within their clock budget");
    end

    initial begin : main_flow
        int total;
        rst    = 1'b1;
        cen    = 1'b0;
        wr_req = 1'b0;
        wr     = '0;
        load_records();
        total = MARGIN_CLKS;
        for (int i = 0; i < q_nsamp.size(); i++)
            total += (q_nsamp[i] + 1) * FRAME_CLKS;
        wd_clocks = total;
        reset_model();
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("wr_ack in reset", 32'(wr_ack), 32'd0);
        check_value("sample_valid in reset", 32'(sample_valid), 32'd0);
        rst = 1'b0;
        for (int r = 0; r < q_ne.size(); r++)
            run_record(r);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/noise_input.txt
# ne nfrq level junk_addr junk_data samples mode expected
# hex: nfrq level addr data expected; mode 0 none, 1 first magnitude, 2 first whole sample
# ne clear from reset, samples stay 0
0 00 000 12 5a 4 2 0000
# slowest noise rate, full level
1 00 3ff 0e a5 20 1 ff
# fastest rate
1 1f 155 ff 00 24 1 55
# mid rate
1 0a 2a8 80 3c 20 1 aa
# ne clear, sample freezes while strobes go on
0 0a 2a8 00 ff 6 0 00
# ne set again
1 05 0c3 20 77 20 1 30
# zero level, only the noise sign shows
1 13 000 f0 01 8 1 00

//--- filelist.f
+incdir+hdl
hdl/noise_pkg.sv
hdl/noise_reg_decode.sv
hdl/noise_slot_counter.sv
hdl/noise_lfsr_gen.sv
hdl/noise_sample_out.sv
hdl/noise_top.sv
sim/noise_tb.sv

//--- Makefile
SIM = obj_dir/Vnoise_tb

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
	verilator --binary --timing --timescale 1ns/1ns --top-module noise_tb \
		-f filelist.f -o Vnoise_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
